// File: design/mcu_pkg.sv
package mcu_pkg;

  // BRAM geometry
  localparam int ADDR_W    = 10;
  localparam int MEM_DEPTH = 1024;
  localparam int DATA_W    = 16;

  // One extra bit so a full-memory read length fits
  localparam int LEN_W = 11;

  // Word buffer between reader and framer
  localparam int FIFO_DEPTH = 8;
  localparam int PTR_W      = 3;
  localparam int LEVEL_W    = 4;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DATA_W-1:0]  word_t;
  typedef logic [LEN_W-1:0]   len_t;
  typedef logic [LEVEL_W-1:0] level_t;

  // Host command, captured on an accepted start
  typedef struct packed {
    addr_t base;
    len_t  length;
  } op_cmd_t;

  // One beat of the output stream
  typedef struct packed {
    word_t data;
    logic  last;
  } stream_beat_t;

  // Global operation state
  typedef enum logic [2:0] {
    OP_IDLE,
    OP_CHECK,
    OP_RUN,
    OP_DONE,
    OP_FAULT
  } op_state_t;

endpackage

// File: design/op_control.sv
`timescale 1ns/10ps

module op_control (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  mcu_pkg::op_cmd_t cmd,
  input  logic             frame_done,
  output logic             go,
  output mcu_pkg::op_cmd_t run_cmd,
  output logic             busy,
  output logic             complete,
  output logic             error
);

  mcu_pkg::op_state_t      state;
  mcu_pkg::op_cmd_t        cmd_q;
  logic [mcu_pkg::LEN_W:0] span;
  logic                    cmd_bad;

  // End of the requested window, one bit wider than a length
  assign span = {{(mcu_pkg::LEN_W + 1 - mcu_pkg::ADDR_W){1'b0}}, cmd_q.base} +
                {1'b0, cmd_q.length};

  assign cmd_bad = (cmd_q.length == '0) ||
                   (span > (mcu_pkg::LEN_W + 1)'(mcu_pkg::MEM_DEPTH));

  assign run_cmd = cmd_q;

  // Command is captured only when the FSM takes the start
  always_ff @(posedge clk) begin
    if (state == mcu_pkg::OP_IDLE && start) begin
      cmd_q <= cmd;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= mcu_pkg::OP_IDLE;
      go       <= 1'b0;
      busy     <= 1'b0;
      complete <= 1'b0;
      error    <= 1'b0;
    end else begin
      // Pulses default low
      go       <= 1'b0;
      complete <= 1'b0;
      error    <= 1'b0;
      case (state)
        mcu_pkg::OP_IDLE: begin
          if (start) begin
            state <= mcu_pkg::OP_CHECK;
          end
        end
        mcu_pkg::OP_CHECK: begin
          busy <= 1'b1;
          if (cmd_bad) begin
            state <= mcu_pkg::OP_FAULT;
          end else begin
            state <= mcu_pkg::OP_RUN;
            go    <= 1'b1;
          end
        end
        mcu_pkg::OP_RUN: begin
          // Framer reports the handshake of the last word
          if (frame_done) begin
            state <= mcu_pkg::OP_DONE;
          end
        end
        mcu_pkg::OP_DONE: begin
          state    <= mcu_pkg::OP_IDLE;
          busy     <= 1'b0;
          complete <= 1'b1;
        end
        mcu_pkg::OP_FAULT: begin
          state <= mcu_pkg::OP_IDLE;
          busy  <= 1'b0;
          error <= 1'b1;
        end
        default: begin
          state <= mcu_pkg::OP_IDLE;
        end
      endcase
    end
  end

endmodule

// File: design/bram_reader.sv
`timescale 1ns/10ps

module bram_reader (
  input  logic            clk,
  input  logic            rst,
  input  logic            go,
  input  mcu_pkg::addr_t  base,
  input  mcu_pkg::len_t   length,
  input  mcu_pkg::level_t free,
  output logic            bram_en,
  output mcu_pkg::addr_t  bram_addr,
  input  mcu_pkg::word_t  bram_rddata,
  output logic            push_valid,
  output mcu_pkg::word_t  push_data
);

  mcu_pkg::addr_t  next_addr;
  mcu_pkg::len_t   remaining;
  logic            rd_pending;
  mcu_pkg::level_t in_flight;
  logic            have_room;

  // Read latency is one cycle, so at most one read is outstanding
  assign in_flight = {{(mcu_pkg::LEVEL_W - 1){1'b0}}, rd_pending};

  // A slot must be left for every read that has not returned yet
  assign have_room = (free > in_flight);

  assign bram_en   = (remaining != '0) && have_room;
  assign bram_addr = next_addr;

  // Returned word goes straight into the FIFO
  assign push_valid = rd_pending;
  assign push_data  = bram_rddata;

  always_ff @(posedge clk) begin
    if (rst) begin
      remaining  <= '0;
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= bram_en;
      if (go) begin
        remaining <= length;
      end else if (bram_en) begin
        remaining <= remaining - 1'b1;
      end
    end
  end

  // Address walks up from the base, one step per issued read
  always_ff @(posedge clk) begin
    if (rst) begin
      next_addr <= '0;
    end else if (go) begin
      next_addr <= base;
    end else if (bram_en) begin
      next_addr <= next_addr + 1'b1;
    end
  end

endmodule

// File: design/word_fifo.sv
`timescale 1ns/10ps

module word_fifo (
  input  logic            clk,
  input  logic            rst,
  input  logic            push_valid,
  input  mcu_pkg::word_t  push_data,
  output mcu_pkg::level_t free,
  output logic            pop_valid,
  output mcu_pkg::word_t  pop_data,
  input  logic            pop_ready
);

  mcu_pkg::word_t              mem [mcu_pkg::FIFO_DEPTH];
  logic [mcu_pkg::PTR_W-1:0]   wr_ptr;
  logic [mcu_pkg::PTR_W-1:0]   rd_ptr;
  mcu_pkg::level_t             level;
  logic                        do_push;
  logic                        do_pop;

  // Upstream never pushes without room, see bram_reader
  assign do_push = push_valid;
  assign do_pop  = pop_valid && pop_ready;

  assign pop_valid = (level != '0);
  assign pop_data  = mem[rd_ptr];
  assign free      = mcu_pkg::LEVEL_W'(mcu_pkg::FIFO_DEPTH) - level;

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy, push and pop in one cycle cancel out
  always_ff @(posedge clk) begin
    if (rst) begin
      level <= '0;
    end else begin
      case ({do_push, do_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

endmodule

// File: design/stream_framer.sv
`timescale 1ns/10ps

module stream_framer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  go,
  input  mcu_pkg::len_t         length,
  input  logic                  in_valid,
  input  mcu_pkg::word_t        in_data,
  output logic                  in_ready,
  output mcu_pkg::stream_beat_t out_beat,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic                  frame_done
);

  mcu_pkg::len_t remaining;
  logic          active;
  logic          xfer;

  assign active = (remaining != '0);

  // Handshake runs straight through while a frame is open
  assign out_valid = in_valid && active;
  assign in_ready  = out_ready && active;
  assign xfer      = out_valid && out_ready;

  assign out_beat.data = in_data;
  assign out_beat.last = (remaining == mcu_pkg::LEN_W'(1));

  // End of frame on acceptance of the last word
  assign frame_done = xfer && out_beat.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      remaining <= '0;
    end else if (go) begin
      remaining <= length;
    end else if (xfer) begin
      remaining <= remaining - 1'b1;
    end
  end

endmodule

// File: design/mem_stream_top.sv
`timescale 1ns/10ps

module mem_stream_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  mcu_pkg::op_cmd_t      cmd,
  output logic                  bram_en,
  output mcu_pkg::addr_t        bram_addr,
  input  mcu_pkg::word_t        bram_rddata,
  output mcu_pkg::stream_beat_t out_beat,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic                  busy,
  output logic                  complete,
  output logic                  error
);

  logic             go;
  mcu_pkg::op_cmd_t run_cmd;
  logic             frame_done;
  logic             push_valid;
  mcu_pkg::word_t   push_data;
  mcu_pkg::level_t  free;
  logic             fifo_valid;
  mcu_pkg::word_t   fifo_data;
  logic             fifo_ready;

  op_control op_control_inst (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .cmd        (cmd),
    .frame_done (frame_done),
    .go         (go),
    .run_cmd    (run_cmd),
    .busy       (busy),
    .complete   (complete),
    .error      (error)
  );

  bram_reader bram_reader_inst (
    .clk         (clk),
    .rst         (rst),
    .go          (go),
    .base        (run_cmd.base),
    .length      (run_cmd.length),
    .free        (free),
    .bram_en     (bram_en),
    .bram_addr   (bram_addr),
    .bram_rddata (bram_rddata),
    .push_valid  (push_valid),
    .push_data   (push_data)
  );

  word_fifo word_fifo_inst (
    .clk        (clk),
    .rst        (rst),
    .push_valid (push_valid),
    .push_data  (push_data),
    .free       (free),
    .pop_valid  (fifo_valid),
    .pop_data   (fifo_data),
    .pop_ready  (fifo_ready)
  );

  stream_framer stream_framer_inst (
    .clk        (clk),
    .rst        (rst),
    .go         (go),
    .length     (run_cmd.length),
    .in_valid   (fifo_valid),
    .in_data    (fifo_data),
    .in_ready   (fifo_ready),
    .out_beat   (out_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .frame_done (frame_done)
  );

endmodule

// File: verification/mem_stream_props.sv
`timescale 1ns/10ps

module mem_stream_props (
  input logic                  clk,
  input logic                  rst,
  input logic                  bram_en,
  input mcu_pkg::stream_beat_t out_beat,
  input logic                  out_valid,
  input logic                  out_ready,
  input logic                  busy,
  input logic                  complete,
  input logic                  error
);

  // Stalled beat holds until accepted
  beat_held: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
    else $error("out_beat or out_valid changed while stalled");

  status_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(complete && error))
    else $error("complete and error high together");

  complete_pulse: assert property (@(posedge clk) disable iff (rst)
    complete |=> !complete)
    else $error("complete longer than one cycle");

  error_pulse: assert property (@(posedge clk) disable iff (rst)
    error |=> !error)
    else $error("error longer than one cycle");

  // Reads only inside an operation
  read_in_op: assert property (@(posedge clk) disable iff (rst)
    !(bram_en && !busy))
    else $error("bram_en high while not busy");

endmodule

bind mem_stream_top mem_stream_props mem_stream_props_inst (
  .clk       (clk),
  .rst       (rst),
  .bram_en   (bram_en),
  .out_beat  (out_beat),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .busy      (busy),
  .complete  (complete),
  .error     (error)
);

// File: verification/mem_stream_tb.sv
`timescale 1ns/10ps

module mem_stream_tb;

  localparam int unsigned SEED = 32'h536b_0657;

  logic                  clk;
  logic                  rst;
  logic                  start;
  mcu_pkg::op_cmd_t      cmd;
  logic                  bram_en;
  mcu_pkg::addr_t        bram_addr;
  mcu_pkg::word_t        bram_rddata;
  mcu_pkg::stream_beat_t out_beat;
  logic                  out_valid;
  logic                  out_ready;
  logic                  busy;
  logic                  complete;
  logic                  error;

  mcu_pkg::word_t mem [mcu_pkg::MEM_DEPTH];
  mcu_pkg::word_t exp_q [$];
  mcu_pkg::addr_t exp_addr;
  int             errors;
  int             ops_run;
  int             ready_mode;
  int             stall_left;
  int             en_cnt;
  int             valid_cnt;
  logic           expect_busy;
  logic           done_seen;
  logic           err_seen;
  logic           timed_out;

  mem_stream_top mem_stream_top_inst (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .cmd         (cmd),
    .bram_en     (bram_en),
    .bram_addr   (bram_addr),
    .bram_rddata (bram_rddata),
    .out_beat    (out_beat),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .busy        (busy),
    .complete    (complete),
    .error       (error)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // BRAM model returns data one cycle after the enable
  always @(posedge clk) begin
    if (bram_en) begin
      bram_rddata <= mem[bram_addr];
    end
  end

  // Sink ready is always on, random per cycle or in long stalls
  always @(negedge clk) begin
    if (ready_mode == 0) begin
      out_ready = 1'b1;
    end else if (ready_mode == 1) begin
      out_ready = ($urandom % 2) == 0;
    end else if (stall_left > 0) begin
      out_ready = 1'b0;
      stall_left--;
    end else if ($urandom % 6 == 0) begin
      out_ready = 1'b0;
      stall_left = 8 + $urandom % 40;
    end else begin
      out_ready = 1'b1;
    end
  end

  task automatic check_beat();
    mcu_pkg::word_t exp_word;
    logic           exp_last;
    if (exp_q.size() == 0) begin
      errors++;
      $display("Transfer of word %h while no word was expected", out_beat.data);
    end else begin
      exp_last = (exp_q.size() == 1);
      exp_word = exp_q.pop_front();
      if (out_beat.data !== exp_word) begin
        errors++;
        $display("[ERROR] out_beat.data expected %h got %h", exp_word, out_beat.data);
      end
      if (out_beat.last !== exp_last) begin
        errors++;
        $display("[ERROR] out_beat.last expected %h got %h", exp_last, out_beat.last);
      end
    end
  endtask

  // Monitor on pre-edge values
  always @(posedge clk) begin
    if (!rst) begin
      if (bram_en) begin
        en_cnt++;
        // Reads walk up from the command base
        if (bram_addr !== exp_addr) begin
          errors++;
          $display("[ERROR] bram_addr expected %h got %h", exp_addr, bram_addr);
        end
        exp_addr = exp_addr + 1'b1;
      end
      if (out_valid) begin
        valid_cnt++;
      end
      if (out_valid && out_ready) begin
        check_beat();
      end
      if (complete) begin
        if (exp_q.size() != 0) begin
          errors++;
          $display("Complete came with %0d words still expected", exp_q.size());
        end
        if (done_seen) begin
          errors++;
          $display("More than one complete pulse for one operation");
        end
        done_seen = 1'b1;
      end
      if (error) begin
        err_seen = 1'b1;
      end
      if (complete || error) begin
        expect_busy = 1'b0;
      end else if (busy !== expect_busy) begin
        errors++;
        $display("[ERROR] busy expected %h got %h", expect_busy, busy);
      end
    end
  end

  // Called on a falling edge and returns on one
  task automatic run_op(input mcu_pkg::addr_t base, input mcu_pkg::len_t length,
                        input logic inject);
    int   limit;
    int   cycles;
    logic bad;
    if (timed_out) begin
      return;
    end
    bad = (length == '0) || (int'(base) + int'(length) > mcu_pkg::MEM_DEPTH);
    if (!bad) begin
      for (int i = 0; i < int'(length); i++) begin
        exp_q.push_back(mem[int'(base) + i]);
      end
    end
    done_seen  = 1'b0;
    err_seen   = 1'b0;
    en_cnt     = 0;
    valid_cnt  = 0;
    exp_addr   = base;
    start      = 1'b1;
    cmd.base   = base;
    cmd.length = length;
    @(negedge clk);
    start = 1'b0;
    @(negedge clk);
    if (busy !== 1'b1) begin
      errors++;
      $display("[ERROR] busy expected 1 got %h after accepted start", busy);
    end
    expect_busy = 1'b1;
    limit  = 100 * int'(length) + 100;
    cycles = 0;
    while (!done_seen && !err_seen && cycles < limit) begin
      // Extra start while busy must be ignored
      if (inject && cycles == 0) begin
        start      = 1'b1;
        cmd.base   = mcu_pkg::addr_t'($urandom % mcu_pkg::MEM_DEPTH);
        cmd.length = mcu_pkg::len_t'(1 + $urandom % 16);
      end else begin
        start = 1'b0;
      end
      @(negedge clk);
      cycles++;
    end
    start = 1'b0;
    if (!done_seen && !err_seen) begin
      timed_out = 1'b1;
      errors++;
      $display("Timeout: operation at base %h length %h never finished", base, length);
    end else if (bad) begin
      if (!err_seen || done_seen || cycles != 2) begin
        errors++;
        $display("Bad command at base %h length %h did not end in one timely error",
                 base, length);
      end
      if (en_cnt != 0 || valid_cnt != 0) begin
        errors++;
        $display("Bad command issued %0d reads and %0d valid beats", en_cnt, valid_cnt);
      end
    end else if (err_seen) begin
      errors++;
      $display("Valid command at base %h length %h ended in error", base, length);
    end
    exp_q.delete();
    ops_run++;
  endtask

  task automatic run_random(input logic inject);
    mcu_pkg::len_t  length;
    mcu_pkg::addr_t base;
    length = mcu_pkg::len_t'(1 + $urandom % 96);
    base   = mcu_pkg::addr_t'($urandom % (mcu_pkg::MEM_DEPTH + 1 - int'(length)));
    run_op(base, length, inject);
  endtask

  initial begin
    void'($urandom(SEED));
    rst         = 1'b1;
    start       = 1'b0;
    cmd         = '0;
    out_ready   = 1'b0;
    bram_rddata = '0;
    ready_mode  = 0;
    stall_left  = 0;
    errors      = 0;
    ops_run     = 0;
    en_cnt      = 0;
    valid_cnt   = 0;
    exp_addr    = '0;
    expect_busy = 1'b0;
    done_seen   = 1'b0;
    err_seen    = 1'b0;
    timed_out   = 1'b0;
    for (int a = 0; a < mcu_pkg::MEM_DEPTH; a++) begin
      mem[a] = mcu_pkg::word_t'($urandom);
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (bram_en || out_valid || busy || complete || error) begin
      errors++;
      $display("Outputs were not all low after reset");
    end

    // Length extremes with the sink always ready
    run_op(10'd0, 11'd1, 1'b0);
    run_op(10'd1023, 11'd1, 1'b0);
    run_op(10'd0, 11'd1024, 1'b0);

    // Random commands issued right after the previous complete
    ready_mode = 1;
    for (int i = 0; i < 20; i++) begin
      run_random(1'b0);
    end

    // Long back-pressure stretches
    ready_mode = 2;
    for (int i = 0; i < 10; i++) begin
      run_random(1'b0);
    end
    run_op(10'd0, 11'd1024, 1'b0);

    // Zero length and out of range commands followed by good ones
    ready_mode = 1;
    run_op(10'd5, 11'd0, 1'b0);
    run_random(1'b0);
    run_op(10'd1000, 11'd25, 1'b0);
    run_random(1'b0);
    run_op(10'd1023, 11'd1024, 1'b0);
    run_random(1'b0);

    // Start pulsed while busy
    for (int i = 0; i < 5; i++) begin
      run_random(1'b1);
    end

    repeat (4) @(negedge clk);
    $display("Operations run: %0d, errors: %0d", ops_run, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
design/mcu_pkg.sv
design/op_control.sv
design/bram_reader.sv
design/word_fifo.sv
design/stream_framer.sv
design/mem_stream_top.sv
verification/mem_stream_props.sv
verification/mem_stream_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_stream_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(BINARY)
	-./$(BINARY) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
